// ==== bpu_consts.svh ====
`ifndef BPU_CONSTS_SVH
`define BPU_CONSTS_SVH

// datapath width
`define XLEN        32

// bimodal counter table, index is pc[9:1]
`define BIM_IDX_W   9
`define BIM_IDX_LO  1

// branch target buffer, index pc[9:2], tag pc[31:10]
`define BTB_IDX_W   8
`define BTB_IDX_LO  2
`define BTB_TAG_W   22
`define BTB_TAG_LO  10

// return stack, pointer has one extra bit to reach "full"
`define RAS_DEPTH   32
`define RAS_PTR_W   6

// rv32 control opcodes
`define OPC_BRANCH  7'b1100011
`define OPC_JAL     7'b1101111
`define OPC_JALR    7'b1100111

`endif

// ==== bpu_pkg.sv ====
`default_nettype none

`include "bpu_consts.svh"

package bpu_pkg;

    // pc or instruction word
    typedef logic [`XLEN-1:0] addr_t;

    // 2-bit saturating counter, msb set means taken
    typedef logic [1:0] counter_t;

    // btb line, 1 + 22 + 32 bits
    typedef struct packed {
        logic                  valid;
        logic [`BTB_TAG_W-1:0] tag;
        addr_t                 target;
    } btb_entry_t;

endpackage

`default_nettype wire

// ==== pred_table.sv ====
`timescale 1ns/10ps
`default_nettype none

module pred_table #(
    parameter type    entry_t   = logic [1:0],
    parameter int     IDX_W     = 9,
    parameter entry_t RESET_VAL = '0
) (
    input  wire logic             clk,
    input  wire logic             rst,
    input  wire logic [IDX_W-1:0] rd_idx_i,
    output entry_t                rd_data_o,
    input  wire logic [IDX_W-1:0] rd2_idx_i,
    output entry_t                rd2_data_o,
    input  wire logic             wr_en_i,
    input  wire logic [IDX_W-1:0] wr_idx_i,
    input  entry_t                wr_data_i
);

    entry_t mem [2**IDX_W];

    // both read ports are asynchronous
    assign rd_data_o  = mem[rd_idx_i];
    assign rd2_data_o = mem[rd2_idx_i];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < 2**IDX_W; i++) begin
                mem[i] <= RESET_VAL;
            end
        end else if (wr_en_i) begin
            mem[wr_idx_i] <= wr_data_i;
        end
    end

endmodule

`default_nettype wire

// ==== bimodal_predictor.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "bpu_consts.svh"

module bimodal_predictor (
    input  wire logic           clk,
    input  wire logic           rst,
    input  bpu_pkg::addr_t      fetch_pc_i,
    output logic                pred_taken_o,
    input  wire logic           ex_valid_i,
    input  bpu_pkg::addr_t      ex_pc_i,
    input  wire logic           ex_taken_i
);

    logic [`BIM_IDX_W-1:0] fetch_idx;
    logic [`BIM_IDX_W-1:0] ex_idx;
    bpu_pkg::counter_t     fetch_cnt;
    bpu_pkg::counter_t     ex_cnt;    // current value at the resolved pc
    bpu_pkg::counter_t     ex_cnt_nxt;

    assign fetch_idx = fetch_pc_i[`BIM_IDX_LO +: `BIM_IDX_W];
    assign ex_idx    = ex_pc_i[`BIM_IDX_LO +: `BIM_IDX_W];

    // saturating step, clamp at 0 and 3
    always_comb begin
        ex_cnt_nxt = ex_cnt;
        if (ex_taken_i) begin
            if (ex_cnt != 2'd3) ex_cnt_nxt = ex_cnt + 2'd1;
        end else begin
            if (ex_cnt != 2'd0) ex_cnt_nxt = ex_cnt - 2'd1;
        end
    end

    pred_table #(
        .entry_t   (bpu_pkg::counter_t),
        .IDX_W     (`BIM_IDX_W),
        .RESET_VAL (bpu_pkg::counter_t'(2'd1))   // weakly not taken
    ) u_cnt_table (
        .clk        (clk),
        .rst        (rst),
        .rd_idx_i   (fetch_idx),
        .rd_data_o  (fetch_cnt),
        .rd2_idx_i  (ex_idx),
        .rd2_data_o (ex_cnt),
        .wr_en_i    (ex_valid_i),
        .wr_idx_i   (ex_idx),
        .wr_data_i  (ex_cnt_nxt)
    );

    assign pred_taken_o = fetch_cnt[1];

endmodule

`default_nettype wire

// ==== branch_target_buffer.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "bpu_consts.svh"

module branch_target_buffer (
    input  wire logic           clk,
    input  wire logic           rst,
    input  bpu_pkg::addr_t      fetch_pc_i,
    output logic                hit_o,
    output bpu_pkg::addr_t      target_o,
    input  wire logic           ex_valid_i,
    input  wire logic           ex_taken_i,
    input  bpu_pkg::addr_t      ex_pc_i,
    input  bpu_pkg::addr_t      ex_target_i
);

    logic [`BTB_IDX_W-1:0] fetch_idx;
    logic [`BTB_TAG_W-1:0] fetch_tag;
    logic [`BTB_IDX_W-1:0] ex_idx;
    bpu_pkg::btb_entry_t   rd_entry;
    bpu_pkg::btb_entry_t   wr_entry;
    logic                  fill;

    assign fetch_idx = fetch_pc_i[`BTB_IDX_LO +: `BTB_IDX_W];
    assign fetch_tag = fetch_pc_i[`BTB_TAG_LO +: `BTB_TAG_W];
    assign ex_idx    = ex_pc_i[`BTB_IDX_LO +: `BTB_IDX_W];

    // only taken resolutions allocate, overwriting whatever sits there
    assign fill = ex_valid_i & ex_taken_i;

    assign wr_entry.valid  = 1'b1;
    assign wr_entry.tag    = ex_pc_i[`BTB_TAG_LO +: `BTB_TAG_W];
    assign wr_entry.target = ex_target_i;

    pred_table #(
        .entry_t   (bpu_pkg::btb_entry_t),
        .IDX_W     (`BTB_IDX_W),
        .RESET_VAL (bpu_pkg::btb_entry_t'('0))   // all lines invalid
    ) u_btb_table (
        .clk        (clk),
        .rst        (rst),
        .rd_idx_i   (fetch_idx),
        .rd_data_o  (rd_entry),
        .rd2_idx_i  (ex_idx),
        .rd2_data_o (),                          // no read-modify-write here
        .wr_en_i    (fill),
        .wr_idx_i   (ex_idx),
        .wr_data_i  (wr_entry)
    );

    assign hit_o    = rd_entry.valid && (rd_entry.tag == fetch_tag);
    assign target_o = rd_entry.target;

endmodule

`default_nettype wire

// ==== return_stack.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "bpu_consts.svh"

module return_stack (
    input  wire logic           clk,
    input  wire logic           rst,
    input  wire logic           push_valid_i,
    input  bpu_pkg::addr_t      push_addr_i,
    input  wire logic           ex_valid_i,
    input  wire logic           ex_taken_i,
    input  bpu_pkg::addr_t      ex_inst_i,
    output logic                empty_o,
    output bpu_pkg::addr_t      top_o
);

    localparam int SLOT_W = `RAS_PTR_W - 1;

    bpu_pkg::addr_t         stack_q [`RAS_DEPTH];
    logic [`RAS_PTR_W-1:0]  sp_q;        // next free slot
    logic [`RAS_PTR_W-1:0]  sp_popped;
    logic [SLOT_W-1:0]      top_slot;
    logic                   pop_req;
    logic                   do_pop;
    logic                   do_push;

    // resolved taken jalr through ra
    assign pop_req = ex_valid_i && ex_taken_i
                     && (ex_inst_i[6:0] == `OPC_JALR)
                     && (ex_inst_i[19:15] == 5'd1);

    assign empty_o = (sp_q == '0);
    assign do_pop  = pop_req && !empty_o;   // pop on empty is dropped

    // pop first, push lands on the resulting pointer
    assign sp_popped = do_pop ? sp_q - 1'b1 : sp_q;
    assign do_push   = push_valid_i && (sp_popped != `RAS_PTR_W'(`RAS_DEPTH));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sp_q <= '0;
        end else begin
            sp_q <= do_push ? sp_popped + 1'b1 : sp_popped;
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            stack_q[sp_popped[SLOT_W-1:0]] <= push_addr_i;
        end
    end

    // wraps to slot 31 when empty, ignored by the selector then
    assign top_slot = sp_q[SLOT_W-1:0] - 1'b1;
    assign top_o    = stack_q[top_slot];

endmodule

`default_nettype wire

// ==== predict_select.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "bpu_consts.svh"

module predict_select (
    input  bpu_pkg::addr_t      fetch_pc_i,
    input  bpu_pkg::addr_t      fetch_inst_i,
    output bpu_pkg::addr_t      lookup_pc_o,
    input  wire logic           bim_taken_i,
    input  wire logic           btb_hit_i,
    input  bpu_pkg::addr_t      btb_target_i,
    input  wire logic           ras_empty_i,
    input  bpu_pkg::addr_t      ras_top_i,
    output logic                is_ctrl_o,
    output logic                pred_taken_o,
    output bpu_pkg::addr_t      pred_pc_o
);

    logic [6:0]     opcode;
    logic [4:0]     rd;
    logic [4:0]     rs1;
    logic           is_branch;
    logic           is_jal;
    logic           is_jalr;
    logic           is_ret;
    bpu_pkg::addr_t b_imm;
    bpu_pkg::addr_t j_imm;
    bpu_pkg::addr_t pc_plus4;

    assign lookup_pc_o = fetch_pc_i;  // tables are indexed by the fetch pc

    assign opcode = fetch_inst_i[6:0];
    assign rd     = fetch_inst_i[11:7];
    assign rs1    = fetch_inst_i[19:15];

    assign is_branch = (opcode == `OPC_BRANCH);
    assign is_jal    = (opcode == `OPC_JAL);
    assign is_jalr   = (opcode == `OPC_JALR);

    // jalr x0, 0(ra) or 0(t0)
    assign is_ret = is_jalr && (rd == 5'd0)
                    && ((rs1 == 5'd1) || (rs1 == 5'd5))
                    && (fetch_inst_i[31:20] == 12'd0);

    assign b_imm = {{20{fetch_inst_i[31]}}, fetch_inst_i[7], fetch_inst_i[30:25],
                    fetch_inst_i[11:8], 1'b0};
    assign j_imm = {{12{fetch_inst_i[31]}}, fetch_inst_i[19:12], fetch_inst_i[20],
                    fetch_inst_i[30:21], 1'b0};

    assign pc_plus4 = fetch_pc_i + 32'd4;

    always_comb begin
        is_ctrl_o    = is_branch | is_jal | is_jalr;
        pred_taken_o = 1'b0;
        pred_pc_o    = pc_plus4;   // fall-through default

        if (is_ret) begin
            if (!ras_empty_i) begin
                pred_taken_o = 1'b1;
                pred_pc_o    = ras_top_i;
            end
        end else if (is_jal) begin
            pred_taken_o = 1'b1;
            pred_pc_o    = btb_hit_i ? btb_target_i : fetch_pc_i + j_imm;
        end else if (is_branch || is_jalr) begin
            pred_taken_o = bim_taken_i;
            if (bim_taken_i) begin
                if (btb_hit_i) begin
                    pred_pc_o = btb_target_i;
                end else if (is_branch) begin
                    pred_pc_o = fetch_pc_i + b_imm;
                end
                // jalr without btb hit has no target, keeps pc+4
            end
        end
    end

endmodule

`default_nettype wire

// ==== bpu_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module bpu_top (
    input  wire logic           clk,
    input  wire logic           rst,
    input  bpu_pkg::addr_t      fetch_pc_i,
    input  bpu_pkg::addr_t      fetch_inst_i,
    input  wire logic           push_valid_i,
    input  bpu_pkg::addr_t      push_addr_i,
    input  wire logic           ex_valid_i,
    input  bpu_pkg::addr_t      ex_pc_i,
    input  bpu_pkg::addr_t      ex_inst_i,
    input  wire logic           ex_taken_i,
    input  bpu_pkg::addr_t      ex_target_i,
    output logic                is_ctrl_o,
    output logic                pred_taken_o,
    output bpu_pkg::addr_t      pred_pc_o
);

    bpu_pkg::addr_t lookup_pc;
    logic           bim_taken;
    logic           btb_hit;
    bpu_pkg::addr_t btb_target;
    logic           ras_empty;
    bpu_pkg::addr_t ras_top;

    bimodal_predictor u_bim (
        .clk          (clk),
        .rst          (rst),
        .fetch_pc_i   (lookup_pc),
        .pred_taken_o (bim_taken),
        .ex_valid_i   (ex_valid_i),
        .ex_pc_i      (ex_pc_i),
        .ex_taken_i   (ex_taken_i)
    );

    branch_target_buffer u_btb (
        .clk          (clk),
        .rst          (rst),
        .fetch_pc_i   (lookup_pc),
        .hit_o        (btb_hit),
        .target_o     (btb_target),
        .ex_valid_i   (ex_valid_i),
        .ex_taken_i   (ex_taken_i),
        .ex_pc_i      (ex_pc_i),
        .ex_target_i  (ex_target_i)
    );

    // pushes from decode, pops from execute
    return_stack u_ras (
        .clk          (clk),
        .rst          (rst),
        .push_valid_i (push_valid_i),
        .push_addr_i  (push_addr_i),
        .ex_valid_i   (ex_valid_i),
        .ex_taken_i   (ex_taken_i),
        .ex_inst_i    (ex_inst_i),
        .empty_o      (ras_empty),
        .top_o        (ras_top)
    );

    predict_select u_sel (
        .fetch_pc_i   (fetch_pc_i),
        .fetch_inst_i (fetch_inst_i),
        .lookup_pc_o  (lookup_pc),
        .bim_taken_i  (bim_taken),
        .btb_hit_i    (btb_hit),
        .btb_target_i (btb_target),
        .ras_empty_i  (ras_empty),
        .ras_top_i    (ras_top),
        .is_ctrl_o    (is_ctrl_o),
        .pred_taken_o (pred_taken_o),
        .pred_pc_o    (pred_pc_o)
    );

endmodule

`default_nettype wire

// ==== tb_clock_gen.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS = 40
) (
    output logic clk_o
);

    initial clk_o = 1'b0;

    always #(PERIOD_NS / 2) clk_o = ~clk_o;  // free running, 50% duty

endmodule

`default_nettype wire

// ==== bpu_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "bpu_consts.svh"

module bpu_tb;

    localparam int CLK_NS      = 40;
    localparam int RST_CYCLES  = 16;
    // one cycle for each check, push or resolution in the six tests
    localparam int TEST_CYCLES = 2 + 1 + 17 + 3 + 7 + 104;
    localparam int WATCHDOG_NS = (RST_CYCLES + TEST_CYCLES + 50) * CLK_NS;

    localparam logic [31:0] NOP_INST = 32'h0000_0013;  // addi x0, x0, 0
    localparam logic [31:0] BEQ_INST = 32'h0000_0863;  // beq x0, x0, +16
    localparam logic [31:0] JAL_INST = 32'h1000_00ef;  // jal ra, +256
    localparam logic [31:0] RET_INST = 32'h0000_8067;  // jalr x0, 0(ra)

    logic        clk;
    logic        rst;
    logic [31:0] fetch_pc;
    logic [31:0] fetch_inst;
    logic        push_valid;
    logic [31:0] push_addr;
    logic        ex_valid;
    logic [31:0] ex_pc;
    logic [31:0] ex_inst;
    logic        ex_taken;
    logic [31:0] ex_target;
    logic        is_ctrl;
    logic        pred_taken;
    logic [31:0] pred_pc;

    // reference state
    logic [1:0]  cnt_m     [512];
    logic        btb_v_m   [256];
    logic [21:0] btb_tag_m [256];
    logic [31:0] btb_tgt_m [256];
    logic [31:0] stack_m   [$];

    string       test_name;
    int          test_checks;
    int          test_errors;
    int          total_tests;
    int          total_checks;
    int          total_errors;
    logic [31:0] addr_a;
    logic [31:0] addr_b;
    logic [31:0] pc_br;
    logic [31:0] pc_j;
    logic [31:0] pc_r;
    logic [31:0] tgt;

    tb_clock_gen #(.PERIOD_NS(CLK_NS)) u_clk (.clk_o(clk));

    bpu_top u_dut (
        .clk          (clk),
        .rst          (rst),
        .fetch_pc_i   (fetch_pc),
        .fetch_inst_i (fetch_inst),
        .push_valid_i (push_valid),
        .push_addr_i  (push_addr),
        .ex_valid_i   (ex_valid),
        .ex_pc_i      (ex_pc),
        .ex_inst_i    (ex_inst),
        .ex_taken_i   (ex_taken),
        .ex_target_i  (ex_target),
        .is_ctrl_o    (is_ctrl),
        .pred_taken_o (pred_taken),
        .pred_pc_o    (pred_pc)
    );

    function automatic logic [31:0] rand_pc();
        return $urandom() & 32'hffff_fffc;  // word aligned
    endfunction

    // expected prediction from the decode and selection rules
    function automatic void predict_model(input logic [31:0] pc, input logic [31:0] inst,
                                          output logic ctrl, output logic taken,
                                          output logic [31:0] npc);
        logic [6:0]  opc;
        logic [31:0] imm_b;
        logic [31:0] imm_j;
        logic        ret;
        logic        hit;
        int          bi;
        int          ti;
        opc   = inst[6:0];
        imm_b = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
        imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
        ret   = (opc == `OPC_JALR) && (inst[11:7] == 5'd0) && (inst[31:20] == 12'd0)
                && ((inst[19:15] == 5'd1) || (inst[19:15] == 5'd5));
        bi    = pc[9:1];
        ti    = pc[9:2];
        hit   = btb_v_m[ti] && (btb_tag_m[ti] == pc[31:10]);
        ctrl  = (opc == `OPC_BRANCH) || (opc == `OPC_JAL) || (opc == `OPC_JALR);
        taken = 1'b0;
        npc   = pc + 32'd4;
        if (ret) begin
            if (stack_m.size() != 0) begin
                taken = 1'b1;
                npc   = stack_m[$];
            end
        end else if (opc == `OPC_JAL) begin
            taken = 1'b1;
            npc   = hit ? btb_tgt_m[ti] : pc + imm_j;
        end else if (ctrl) begin
            taken = (cnt_m[bi] >= 2'd2);
            if (taken && hit) npc = btb_tgt_m[ti];
            else if (taken && opc == `OPC_BRANCH) npc = pc + imm_b;
        end
    endfunction

    task automatic check_pred(input logic [31:0] pc, input logic [31:0] inst);
        logic        exp_ctrl;
        logic        exp_taken;
        logic [31:0] exp_pc;
        @(negedge clk);
        ex_valid   = 1'b0;
        push_valid = 1'b0;
        fetch_pc   = pc;
        fetch_inst = inst;
        #1;
        predict_model(pc, inst, exp_ctrl, exp_taken, exp_pc);
        test_checks++;
        assert ({is_ctrl, pred_taken, pred_pc} === {exp_ctrl, exp_taken, exp_pc}) else begin
            $display("Mismatch %s pc %h: expected ctrl/taken/next %b/%b/%h, actual %b/%b/%h",
                     test_name, pc, exp_ctrl, exp_taken, exp_pc, is_ctrl, pred_taken, pred_pc);
            test_errors++;
        end
    endtask

    task automatic resolve(input logic [31:0] pc, input logic [31:0] inst, input logic taken,
                           input logic [31:0] target);
        int bi;
        int ti;
        bi = pc[9:1];
        ti = pc[9:2];
        @(negedge clk);
        push_valid = 1'b0;
        ex_valid   = 1'b1;
        ex_pc      = pc;
        ex_inst    = inst;
        ex_taken   = taken;
        ex_target  = target;
        @(posedge clk);
        // model takes the same edge
        if (taken && cnt_m[bi] != 2'd3) cnt_m[bi] = cnt_m[bi] + 2'd1;
        if (!taken && cnt_m[bi] != 2'd0) cnt_m[bi] = cnt_m[bi] - 2'd1;
        if (taken) begin
            btb_v_m[ti]   = 1'b1;
            btb_tag_m[ti] = pc[31:10];
            btb_tgt_m[ti] = target;
        end
        if (taken && inst[6:0] == `OPC_JALR && inst[19:15] == 5'd1 && stack_m.size() != 0)
            void'(stack_m.pop_back());
    endtask

    task automatic push_return(input logic [31:0] addr);
        @(negedge clk);
        ex_valid   = 1'b0;
        push_valid = 1'b1;
        push_addr  = addr;
        @(posedge clk);
        if (stack_m.size() < `RAS_DEPTH) stack_m.push_back(addr);  // full stack drops it
    endtask

    task automatic start_test(input string name);
        test_name   = name;
        test_checks = 0;
        test_errors = 0;
    endtask

    task automatic end_test();
        $display("test %s: %0d checks, %0d errors", test_name, test_checks, test_errors);
        total_tests++;
        total_checks += test_checks;
        total_errors += test_errors;
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired before the tests finished");
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin
        void'($urandom(19943));
        rst        = 1'b1;
        fetch_pc   = '0;
        fetch_inst = NOP_INST;
        push_valid = 1'b0;
        push_addr  = '0;
        ex_valid   = 1'b0;
        ex_pc      = '0;
        ex_inst    = '0;
        ex_taken   = 1'b0;
        ex_target  = '0;
        for (int i = 0; i < 512; i++) cnt_m[i] = 2'd1;
        for (int i = 0; i < 256; i++) begin
            btb_v_m[i]   = 1'b0;
            btb_tag_m[i] = '0;
            btb_tgt_m[i] = '0;
        end
        repeat (RST_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        start_test("reset_state");
        check_pred(rand_pc(), NOP_INST);
        check_pred(rand_pc(), BEQ_INST);
        end_test();

        start_test("jal_cold_btb");
        check_pred(rand_pc(), JAL_INST);
        end_test();

        start_test("bimodal_train");
        pc_br = rand_pc();
        tgt   = rand_pc();
        repeat (2) resolve(pc_br, BEQ_INST, 1'b1, tgt);
        check_pred(pc_br, BEQ_INST);
        for (int i = 0; i < 3; i++) begin  // saturate at three
            resolve(pc_br, BEQ_INST, 1'b1, tgt);
            check_pred(pc_br, BEQ_INST);
        end
        for (int i = 0; i < 4; i++) begin
            resolve(pc_br, BEQ_INST, 1'b0, tgt);
            check_pred(pc_br, BEQ_INST);
        end
        end_test();

        start_test("btb_tag_match");
        pc_j = rand_pc();
        resolve(pc_j, JAL_INST, 1'b1, rand_pc());
        check_pred(pc_j, JAL_INST);
        check_pred(pc_j ^ 32'h0000_0400, JAL_INST);  // same index but other tag
        end_test();

        start_test("ras_push_pop");
        addr_a = rand_pc();
        addr_b = rand_pc();
        pc_r   = rand_pc();
        push_return(addr_a);
        push_return(addr_b);
        check_pred(pc_r, RET_INST);
        resolve(pc_r, RET_INST, 1'b1, addr_b);
        check_pred(pc_r, RET_INST);
        resolve(pc_r, RET_INST, 1'b1, addr_a);
        check_pred(pc_r, RET_INST);
        end_test();

        start_test("ras_overflow");
        for (int i = 0; i < 33; i++) push_return(rand_pc());
        check_pred(pc_r, RET_INST);
        for (int i = 0; i < 32; i++) begin
            resolve(pc_r, RET_INST, 1'b1, stack_m[$]);
            check_pred(pc_r, RET_INST);
        end
        for (int i = 0; i < 3; i++) begin  // pops past empty
            resolve(pc_r, RET_INST, 1'b1, pc_r);
            check_pred(pc_r, RET_INST);
        end
        end_test();

        $display("tests %0d, checks %0d, errors %0d", total_tests, total_checks, total_errors);
        if (total_errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+.
bpu_pkg.sv
pred_table.sv
bimodal_predictor.sv
branch_target_buffer.sv
return_stack.sv
predict_select.sv
bpu_top.sv
tb_clock_gen.sv
bpu_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --top-module bpu_tb -f files.f -o bpu_sim
./obj_dir/bpu_sim | tee sim.log

if grep -qF "*** TEST PASSED ***" sim.log; then
    exit 0
else
    exit 1
fi
